// File: list.f
+incdir+tests
logic/controlPkg.sv
logic/audioPkg.sv
logic/tickGenerator.sv
logic/inputSmoother.sv
logic/modeController.sv
logic/toneSynth.sv
logic/dacSerializer.sv
logic/segmentDisplay.sv
logic/musicBox.sv
tests/musicBoxTb.sv

// File: run.sh
#!/bin/sh
# Build and run the music box testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f list.f --top-module musicBoxTb -o simMusicBox
output=$(./obj_dir/simMusicBox || true)
echo "$output"
if echo "$output" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1

// File: tests/tbChecks.svh
/*
 Check helpers for the music box testbench
 Value compare with an error line, pass and error counters, test lines
 Included inside the testbench module body
*/
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int checkCount;
int errorCount;
int testCount;
int errorsAtTestStart;	// Snapshot taken when a test begins

// Compare one value, report at once on mismatch
task automatic checkValue(input string what, input longint got, input longint want);
	checkCount++;
	if (got !== want) begin
		errorCount++;
		$display("ERROR at %0d ns: %s is %0d, expected %0d", $time, what, got, want);
	end
endtask

// One line per finished test
task automatic endTest(input string name);
	testCount++;
	$display("%s %s (%0d errors)", (errorCount == errorsAtTestStart) ? "PASS" : "FAIL",
		name, errorCount - errorsAtTestStart);
	errorsAtTestStart = errorCount;
endtask

task automatic reportCounts();
	$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
endtask

`endif

// File: tests/musicBoxTb.sv
/*
 Testbench for the keyboard music box
 Drives keys and mode buttons, rebuilds the serial DAC frames and checks
 tone run lengths, display digits and the bee mode LED against the tables
*/
`timescale 1ns/1ps

module musicBoxTb
	import controlPkg::*;
	import audioPkg::*;
();

	localparam int MS          = TICK_1KHZ_DIV;	// Clock cycles per ms
	localparam int CYCLE_LIMIT = 500 * MS;	// Tests need about 130 ms
	localparam int HIGH_CODE   = TONE_HIGH * (2 ** DAC_SCALE_SHIFT);	// 4080
	localparam logic [6:0] SEG_DIGIT [7] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02	// 0..6, active low
	};
	localparam noteT SILENCE [SONG_LEN] = '{default: 3'd0};

	logic                clock50Mhz = 1'b0;
	logic                rstN;
	keyBitsT             keysN;
	modeButtonsT         buttonsN;
	logic                spiSclk;
	logic                spiSyncN;
	logic                spiDin;
	logic [NUM_LEDS-1:0] led;
	segDigitsT           segments;
	longint              cycles;

	`include "tbChecks.svh"

	musicBox dut (
		.clock50Mhz, .rstN, .keysN, .buttonsN,
		.spiSclk, .spiSyncN, .spiDin, .led, .segments
	);

	always #2 clock50Mhz = ~clock50Mhz;	// 4 ns period

	// Run limit --------------------
	always @(posedge clock50Mhz) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles before the tests ended", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// Frame decoder --------------------
	logic [FRAME_W-1:0] shiftIn;
	int                 bitsIn;
	logic [FRAME_W-1:0] frames [$];

	always @(negedge spiSclk) begin
		if (!spiSyncN) begin	// DAC takes data on the falling edge
			shiftIn = {shiftIn[FRAME_W-2:0], spiDin};
			bitsIn++;
			if (bitsIn == FRAME_W) begin
				frames.push_back(shiftIn);	// MSB first, control nibble on top
				bitsIn = 0;
			end
		end
	end

	// Reference model --------------------
	function automatic int refRunLength(input noteT n);
		return int'(HALF_PERIOD[n]);	// Samples per half wave
	endfunction

	noteT expTones [$];	// Expected tone order, rests dropped
	int   tonePos;
	int   fullRuns [SONG_LEN];
	int   strayRuns;	// Runs cut by a note edge
	int   frameCount;
	int   nonzeroFrames;
	int   runValue;
	int   runLen;

	// Sort a finished run into the current note, the next note or an edge
	task automatic closeRun(input int len);
		if (expTones.size() > 0 && len == refRunLength(expTones[tonePos])) begin
			fullRuns[tonePos]++;
		end else if (tonePos + 1 < expTones.size() &&
				len == refRunLength(expTones[tonePos + 1])) begin
			tonePos++;	// Song moved on
			fullRuns[tonePos]++;
		end else begin
			strayRuns++;
		end
	endtask

	task automatic watchNotes(input noteT list [SONG_LEN]);
		expTones.delete();
		foreach (list[i]) begin
			fullRuns[i] = 0;
			if (list[i] != 3'd0)
				expTones.push_back(list[i]);	// A rest makes no tone runs
		end
		tonePos       = 0;
		strayRuns     = 0;
		nonzeroFrames = 0;
	endtask

	task automatic checkTones(input string name);
		checkValue({name, " last tone reached"}, tonePos, expTones.size() - 1);
		foreach (expTones[i])
			checkValue($sformatf("%s full runs of note %0d", name, expTones[i]),
				fullRuns[i] >= 2, 1);
		checkValue({name, " odd length runs within limit"},
			strayRuns <= 2 * expTones.size(), 1);
	endtask

	// Frame compare --------------------
	always @(posedge clock50Mhz) begin
		logic [FRAME_W-1:0] frame;
		int                 data;
		while (frames.size() > 0) begin
			frame = frames.pop_front();
			data  = int'(frame[DAC_W-1:0]);
			checkValue("frame control bits", frame[FRAME_W-1:DAC_W], 0);
			checkValue("frame level is 0 or full tone", data == 0 || data == HIGH_CODE, 1);
			frameCount++;
			if (data != 0)
				nonzeroFrames++;
			if (data == runValue) begin
				runLen++;
			end else begin
				closeRun(runLen);	// Level flipped
				runValue = data;
				runLen   = 1;
			end
		end
	end

	task automatic waitMs(input int ms);
		repeat (ms * MS) @(negedge clock50Mhz);
	endtask

	// Poll digit 0 until it shows the mode, or give up
	task automatic waitForMode(input int m, input int limitMs);
		int waited;
		waited = 0;
		while (segments[0] !== SEG_DIGIT[m] && waited < limitMs * MS) begin
			@(negedge clock50Mhz);
			waited++;
		end
		checkValue($sformatf("digit 0 showing mode %0d", m), segments[0], SEG_DIGIT[m]);
	endtask

	// Tests --------------------
	initial begin
		int     key;
		int     glitch;
		int     digitMoves;
		noteT   keyNote;
		noteT   keyList [SONG_LEN];
		logic   bee;
		longint songStart;
		longint songCycles;

		void'($urandom(66));
		rstN     = 1'b0;
		keysN    = '1;	// All released
		buttonsN = '1;
		repeat (16) @(negedge clock50Mhz);
		rstN = 1'b1;

		@(negedge clock50Mhz);
		checkValue("spiSyncN after reset", spiSyncN, 1);
		checkValue("spiSclk after reset", spiSclk, 0);
		checkValue("led after reset", led, 0);
		checkValue("digit 0 after reset", segments[0], SEG_DIGIT[0]);
		for (int d = 2; d < NUM_DIGITS; d++)
			checkValue($sformatf("digit %0d blank", d), segments[d], 7'h7F);	// All off
		watchNotes(SILENCE);
		waitMs(2);
		checkValue("frames seen", frameCount > 0, 1);
		checkValue("nonzero frames after reset", nonzeroFrames, 0);
		endTest("reset state");

		// Held key, lowest note is key 0
		key     = $urandom % NUM_KEYS;
		keyNote = noteT'(key + 1);
		keyList = '{keyNote, 3'd0, 3'd0, 3'd0};
		watchNotes(keyList);
		keysN[key] = 1'b0;
		waitMs(5);
		checkValue("digit 1 while key held", segments[1], SEG_DIGIT[keyNote]);
		waitMs(5);
		keysN[key] = 1'b1;
		waitMs(5);
		checkValue("silent frames after release", runValue == 0 && runLen >= 32, 1);
		checkTones("held key");
		endTest($sformatf("held key %0d", key));

		glitch = 1 + $urandom % (MS - 1);	// Under one tick interval
		watchNotes(SILENCE);
		digitMoves = 0;
		keysN[key] = 1'b0;
		repeat (glitch) @(negedge clock50Mhz);
		keysN[key] = 1'b1;
		repeat (5 * MS) begin
			@(negedge clock50Mhz);
			if (segments[1] !== SEG_DIGIT[0])
				digitMoves++;
		end
		checkValue("digit 1 changes after glitch", digitMoves, 0);
		checkValue("nonzero frames after glitch", nonzeroFrames, 0);
		endTest($sformatf("glitch of %0d cycles", glitch));

		bee = 1'b0;
		repeat (3) begin
			buttonsN.beeMode = 1'b0;
			waitMs(5);
			buttonsN.beeMode = 1'b1;
			waitMs(5);
			bee = ~bee;	// One toggle per press
			checkValue("led with bee mode", led, bee);
		end
		endTest("bee mode toggle");

		watchNotes(SONG0);
		buttonsN.playSong0 = 1'b0;
		waitForMode(MODE_SONG0, 5);
		songStart = cycles;
		buttonsN.playSong0 = 1'b1;
		waitMs(2);
		checkValue("digit 0 early in song 0", segments[0], SEG_DIGIT[MODE_SONG0]);
		keysN[NUM_KEYS-1] = 1'b0;	// Ignored while a song plays
		waitMs(12);
		checkValue("digit 0 with key held", segments[0], SEG_DIGIT[MODE_SONG0]);
		keysN[NUM_KEYS-1] = 1'b1;
		waitForMode(MODE_FREE, 30);
		songCycles = cycles - songStart;
		checkValue("song 0 length near SONG_LEN notes",
			songCycles >= (SONG_LEN * NOTE_MS - 1) * MS &&
			songCycles <= (SONG_LEN * NOTE_MS + 1) * MS, 1);
		waitMs(1);
		checkTones("song 0");
		endTest("song 0");

		// Song 1 ends on a rest
		watchNotes(SONG1);
		buttonsN.playSong1 = 1'b0;
		waitForMode(MODE_SONG1, 5);
		buttonsN.playSong1 = 1'b1;
		waitForMode(MODE_FREE, 40);
		checkValue("rest frames before song 1 ends", runValue == 0 && runLen >= 200, 1);
		waitMs(1);
		checkTones("song 1");
		endTest("song 1");

		reportCounts();
		if (errorCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: logic/musicBox.sv
/*
 Top level of the keyboard music box
 Connects buttons and keys through smoothing to the mode controller,
 the tone synth, the serial DAC and the seven segment display
*/
`timescale 1ns/1ps

module musicBox
	import controlPkg::*;
	import audioPkg::*;
(
	input  logic                clock50Mhz,
	input  logic                rstN,
	input  keyBitsT             keysN,
	input  modeButtonsT         buttonsN,
	output logic                spiSclk,
	output logic                spiSyncN,
	output logic                spiDin,
	output logic [NUM_LEDS-1:0] led,
	output segDigitsT           segments
);

	logic        tick1Khz;
	logic        sampleTick;
	keyBitsT     keys;	// Clean, active high
	modeButtonsT buttons;
	playModeT    mode;
	noteT        note;
	logic        beeMode;
	sampleT      sample;

	// Timing --------------------
	tickGenerator ticks (.clock50Mhz, .rstN, .tick1Khz, .sampleTick);

	// Input smoothing --------------------
	inputSmoother #(.payloadT(keyBitsT)) keySmoother (
		.clock50Mhz, .rstN, .tick1Khz,
		.rawN (keysN),
		.clean(keys)
	);

	inputSmoother #(.payloadT(modeButtonsT)) buttonSmoother (
		.clock50Mhz, .rstN, .tick1Khz,
		.rawN (buttonsN),
		.clean(buttons)
	);

	// Mode and audio --------------------
	modeController control (
		.clock50Mhz, .rstN, .tick1Khz,
		.buttons, .keys, .mode, .note, .beeMode
	);

	toneSynth synth (.clock50Mhz, .rstN, .sampleTick, .note, .sample);

	dacSerializer dac (
		.clock50Mhz, .rstN, .sampleTick, .sample,
		.spiSclk, .spiSyncN, .spiDin
	);

	segmentDisplay display (.mode, .note, .segments);

	assign led = {{(NUM_LEDS - 1){1'b0}}, beeMode};	// LED 0 shows bee mode

endmodule

// File: logic/segmentDisplay.sv
/*
 Seven segment display encoder
 Digit 0 shows the mode number, digit 1 the note being played
 Remaining digits are blank, every segment is active low
*/
`timescale 1ns/1ps

module segmentDisplay
	import controlPkg::*;
	import audioPkg::*;
(
	input  playModeT  mode,
	input  noteT      note,
	output segDigitsT segments
);

	// Decimal digit to gfedcba, active low
	function automatic logic [6:0] digitToSeg(input logic [3:0] value);
		case (value)
			4'd0:    return 7'b1000000;
			4'd1:    return 7'b1111001;
			4'd2:    return 7'b0100100;
			4'd3:    return 7'b0110000;
			4'd4:    return 7'b0011001;
			4'd5:    return 7'b0010010;
			4'd6:    return 7'b0000010;
			4'd7:    return 7'b1111000;
			4'd8:    return 7'b0000000;
			4'd9:    return 7'b0010000;
			default: return SEG_BLANK;	// Not a decimal digit
		endcase
	endfunction

	always_comb begin
		for (int d = 0; d < NUM_DIGITS; d++)
			segments[d] = SEG_BLANK;
		segments[0] = digitToSeg({2'b00, mode});
		segments[1] = digitToSeg({1'b0, note});	// Rest reads as 0
	end

endmodule

// File: logic/dacSerializer.sv
/*
 Serial DAC output
 Latches the scaled sample on each sample tick and shifts a 16-bit frame
 MSB first, data moves on SCLK rise and is taken by the DAC on SCLK fall
*/
`timescale 1ns/1ps

module dacSerializer
	import audioPkg::*;
(
	input  logic   clock50Mhz,
	input  logic   rstN,
	input  logic   sampleTick,
	input  sampleT sample,
	output logic   spiSclk,
	output logic   spiSyncN,
	output logic   spiDin
);

	localparam int PHASE_W = $clog2(2 * SCLK_HALF);
	localparam int BIT_W   = $clog2(FRAME_W);

	logic [DAC_W-1:0]   scaled;
	logic [FRAME_W-1:0] shiftReg;	// MSB drives spiDin
	logic [PHASE_W-1:0] phaseCnt;	// Position inside one SCLK period
	logic [BIT_W-1:0]   bitCnt;
	logic               startPending;	// Frame latched, SYNC next cycle

	assign scaled = DAC_W'(sample) << DAC_SCALE_SHIFT;	// 8 to 12 bits
	assign spiDin = shiftReg[FRAME_W-1];

	// Frame shifter --------------------
	always_ff @(posedge clock50Mhz or negedge rstN) begin
		if (!rstN) begin
			shiftReg     <= '0;
			startPending <= 1'b0;
			spiSyncN     <= 1'b1;
			spiSclk      <= 1'b0;
			phaseCnt     <= '0;
			bitCnt       <= '0;
		end else if (sampleTick) begin
			shiftReg     <= {FRAME_CTRL, scaled};
			startPending <= 1'b1;
		end else if (startPending) begin
			startPending <= 1'b0;
			spiSyncN     <= 1'b0;	// Frame begins
			spiSclk      <= 1'b1;	// First bit already on spiDin
			phaseCnt     <= '0;
			bitCnt       <= '0;
		end else if (!spiSyncN) begin
			phaseCnt <= phaseCnt + 1'b1;
			if (phaseCnt == PHASE_W'(SCLK_HALF - 1)) begin
				spiSclk <= 1'b0;	// DAC samples here
			end else if (phaseCnt == PHASE_W'(2 * SCLK_HALF - 1)) begin
				phaseCnt <= '0;
				if (bitCnt == BIT_W'(FRAME_W - 1)) begin
					spiSyncN <= 1'b1;	// All 16 bits out
				end else begin
					bitCnt   <= bitCnt + 1'b1;
					spiSclk  <= 1'b1;
					shiftReg <= {shiftReg[FRAME_W-2:0], 1'b0};	// Next bit
				end
			end
		end
	end

	// Frame must finish well inside one sample period
	assert property (@(posedge clock50Mhz) disable iff (!rstN)
		sampleTick |-> spiSyncN);

endmodule

// File: logic/toneSynth.sv
/*
 Square wave tone generator
 Steps once per sample tick, toggling between TONE_HIGH and 0
 Each level lasts the note's half period, counted in samples
*/
`timescale 1ns/1ps

module toneSynth
	import audioPkg::*;
(
	input  logic   clock50Mhz,
	input  logic   rstN,
	input  logic   sampleTick,
	input  noteT   note,
	output sampleT sample
);

	logic [HALF_W-1:0] halfCount;	// Samples emitted at the current level
	logic [HALF_W-1:0] halfPeriod;
	noteT              lastNote;	// Note seen on the previous tick
	logic              phase;	// High half of the square wave

	assign halfPeriod = HALF_PERIOD[note];

	// Phase and half period counter --------------------
	always_ff @(posedge clock50Mhz or negedge rstN) begin
		if (!rstN) begin
			halfCount <= '0;
			lastNote  <= '0;
			phase     <= 1'b0;
		end else if (sampleTick) begin
			lastNote <= note;
			if (note == '0) begin
				phase     <= 1'b0;	// Rest stays silent
				halfCount <= '0;
			end else if (note != lastNote) begin
				phase     <= 1'b1;	// New note restarts high
				halfCount <= HALF_W'(1);
			end else if (halfCount == halfPeriod) begin
				phase     <= ~phase;
				halfCount <= HALF_W'(1);
			end else begin
				halfCount <= halfCount + 1'b1;
			end
		end
	end

	assign sample = phase ? TONE_HIGH : '0;

endmodule

// File: logic/modeController.sv
/*
 Mode register block of the music box
 Holds free play or song mode, the song position and the bee mode flag
 Picks the note that the tone synth plays from keys or a song table
*/
`timescale 1ns/1ps

module modeController
	import controlPkg::*;
	import audioPkg::*;
(
	input  logic        clock50Mhz,
	input  logic        rstN,
	input  logic        tick1Khz,
	input  modeButtonsT buttons,
	input  keyBitsT     keys,
	output playModeT    mode,
	output noteT        note,
	output logic        beeMode
);

	localparam int IDX_W  = $clog2(SONG_LEN);
	localparam int NOTE_W = $clog2(NOTE_MS);

	modeButtonsT       prevButtons;	// Edge detect history
	modeButtonsT       rise;
	logic [IDX_W:0]    songPos;	// One spare bit so overrun would show
	logic [NOTE_W-1:0] noteTimer;	// 1 kHz ticks into the current note
	noteT              keyNote;

	assign rise = buttons & ~prevButtons;

	// Mode register --------------------
	always_ff @(posedge clock50Mhz or negedge rstN) begin
		if (!rstN) begin
			mode        <= MODE_FREE;
			songPos     <= '0;
			noteTimer   <= '0;
			beeMode     <= 1'b0;
			prevButtons <= '0;
		end else begin
			prevButtons <= buttons;
			if (rise.beeMode)
				beeMode <= ~beeMode;	// Toggle per press

			if (mode == MODE_FREE) begin
				songPos   <= '0;
				noteTimer <= '0;
				if (rise.playSong0)
					mode <= MODE_SONG0;
				else if (rise.playSong1)
					mode <= MODE_SONG1;
			end else if (tick1Khz) begin	// Song buttons ignored here
				if (noteTimer == NOTE_W'(NOTE_MS - 1)) begin
					noteTimer <= '0;
					if (songPos == (IDX_W + 1)'(SONG_LEN - 1)) begin
						mode    <= MODE_FREE;	// Last note done
						songPos <= '0;
					end else begin
						songPos <= songPos + 1'b1;
					end
				end else begin
					noteTimer <= noteTimer + 1'b1;
				end
			end
		end
	end

	// Lowest held key wins
	always_comb begin
		keyNote = '0;
		for (int k = NUM_KEYS - 1; k >= 0; k--) begin
			if (keys[k])
				keyNote = noteT'(k + 1);
		end
	end

	always_comb begin
		unique case (mode)
			MODE_SONG0: note = SONG0[songPos[IDX_W-1:0]];
			MODE_SONG1: note = SONG1[songPos[IDX_W-1:0]];
			default:    note = keyNote;	// Free play
		endcase
	end

	// Song position never runs past the table while a song plays
	assert property (@(posedge clock50Mhz) disable iff (!rstN)
		(mode != MODE_FREE) |-> (songPos < (IDX_W + 1)'(SONG_LEN)));

endmodule

// File: logic/inputSmoother.sv
/*
 Debouncer for a bundle of active-low board inputs
 Synchronises, inverts, then waits for agreeing 1 kHz ticks per bit
 The payload type is a parameter so keys and mode buttons share it
*/
`timescale 1ns/1ps

module inputSmoother
	import controlPkg::*;
#(
	parameter type payloadT = logic
) (
	input  logic    clock50Mhz,
	input  logic    rstN,
	input  logic    tick1Khz,
	input  payloadT rawN,
	output payloadT clean
);

	localparam int W     = $bits(payloadT);
	localparam int CNT_W = $clog2(SMOOTH_TICKS);

	logic [W-1:0] syncMeta;	// First sync stage, still active low
	logic [W-1:0] syncRaw;
	logic [W-1:0] cleanBits;	// Active high

	// Synchroniser --------------------
	always_ff @(posedge clock50Mhz or negedge rstN) begin
		if (!rstN) begin
			syncMeta <= '1;	// Idle level of the pins
			syncRaw  <= '1;
		end else begin
			syncMeta <= rawN;
			syncRaw  <= syncMeta;
		end
	end

	// Per bit stability counter --------------------
	for (genvar b = 0; b < W; b++) begin : gBit
		logic [CNT_W-1:0] agree;	// Ticks seen at the opposite level
		logic             level;

		always_ff @(posedge clock50Mhz or negedge rstN) begin
			if (!rstN) begin
				agree <= '0;
				level <= 1'b0;
			end else if (tick1Khz) begin
				if (!syncRaw[b] == level) begin
					agree <= '0;	// Bounce, start over
				end else if (agree == CNT_W'(SMOOTH_TICKS - 1)) begin
					agree <= '0;
					level <= ~level;	// Held long enough
				end else begin
					agree <= agree + 1'b1;
				end
			end
		end

		assign cleanBits[b] = level;
	end

	assign clean = payloadT'(cleanBits);

	// Output may only move on the edge after a 1 kHz tick
	assert property (@(posedge clock50Mhz) disable iff (!rstN)
		!$stable(cleanBits) |-> $past(tick1Khz));

endmodule

// File: logic/tickGenerator.sv
/*
 Tick strobes for the music box
 Free running dividers on the 50 MHz clock, one cycle pulse each
 tick1Khz paces smoothing and songs, sampleTick paces audio and the DAC
*/
`timescale 1ns/1ps

module tickGenerator
	import controlPkg::*;
(
	input  logic clock50Mhz,
	input  logic rstN,
	output logic tick1Khz,
	output logic sampleTick
);

	localparam int NUM_TICKS = 2;
	localparam int DIVISORS [NUM_TICKS] = '{TICK_1KHZ_DIV, TICK_SAMPLE_DIV};

	logic [NUM_TICKS-1:0] ticks;	// Registered strobes

	for (genvar i = 0; i < NUM_TICKS; i++) begin : gDivider
		localparam int CNT_W = $clog2(DIVISORS[i]);
		logic [CNT_W-1:0] count;

		always_ff @(posedge clock50Mhz or negedge rstN) begin
			if (!rstN) begin
				count    <= '0;
				ticks[i] <= 1'b0;
			end else if (count == CNT_W'(DIVISORS[i] - 1)) begin
				count    <= '0;	// Wrap and fire
				ticks[i] <= 1'b1;
			end else begin
				count    <= count + 1'b1;
				ticks[i] <= 1'b0;
			end
		end
	end

	assign tick1Khz   = ticks[0];
	assign sampleTick = ticks[1];

endmodule

// File: logic/audioPkg.sv
/*
 Audio side definitions for the music box
 Sample and DAC widths, note table, stored songs and the DAC frame layout
 Imported by the tone synth, the DAC serializer and the mode controller
*/
package audioPkg;

	// Widths --------------------
	localparam int SAMPLE_W        = 8;
	localparam int DAC_W           = 12;
	localparam int FRAME_W         = 16;	// Control nibble then data, MSB first
	localparam int DAC_SCALE_SHIFT = 4;	// 255 * 16 = 4080, near full scale
	localparam int SCLK_HALF       = 2;	// Clocks per SCLK half period
	localparam int HALF_W          = 8;	// Holds the longest half period

	localparam logic [FRAME_W-DAC_W-1:0] FRAME_CTRL = '0;	// Normal operation

	typedef logic [SAMPLE_W-1:0] sampleT;
	typedef logic [2:0] noteT;	// 0 is rest, 1..6 are tones

	localparam int NUM_NOTES = 7;

	// Half period of each note, counted in samples
	localparam logic [HALF_W-1:0] HALF_PERIOD [NUM_NOTES] = '{
		8'd0,	// Rest
		8'd61,
		8'd54,
		8'd48,
		8'd45,
		8'd40,
		8'd36	// Highest tone
	};

	// Songs --------------------
	localparam int SONG_LEN = 4;

	localparam noteT SONG0 [SONG_LEN] = '{3'd1, 3'd2, 3'd3, 3'd4};	// Rising run
	localparam noteT SONG1 [SONG_LEN] = '{3'd6, 3'd4, 3'd2, 3'd0};	// Falls, ends on rest

	localparam sampleT TONE_HIGH = 8'd255;

endpackage

// File: logic/controlPkg.sv
/*
 Control side definitions for the music box
 Tick divisors, debounce length, play modes and button bundles
 Imported by the smoother, the mode controller, the display and the top
*/
package controlPkg;

	// Timing --------------------
	localparam int TICK_1KHZ_DIV   = 50000;	// 50 MHz down to 1 kHz
	localparam int TICK_SAMPLE_DIV = 1562;	// Roughly 32 kHz sample rate
	localparam int SMOOTH_TICKS    = 3;	// Agreeing 1 kHz ticks before a flip
	localparam int NOTE_MS         = 8;	// Song note length in ms

	// Board --------------------
	localparam int NUM_KEYS   = 6;
	localparam int NUM_LEDS   = 10;
	localparam int NUM_DIGITS = 6;
	localparam logic [6:0] SEG_BLANK = 7'h7F;	// Active low, all off

	typedef enum logic [1:0] {
		MODE_FREE  = 2'd0,	// Keys play directly
		MODE_SONG0 = 2'd1,
		MODE_SONG1 = 2'd2
	} playModeT;

	// Active low at the pins, active high once smoothed
	typedef struct packed {
		logic playSong0;
		logic playSong1;
		logic beeMode;
	} modeButtonsT;

	typedef logic [NUM_KEYS-1:0] keyBitsT;	// Bit 0 is the lowest key

	typedef logic [NUM_DIGITS-1:0][6:0] segDigitsT;	// gfedcba per digit

endpackage
